/* flist.f */
+incdir+hw
hw/core_pkg.sv
hw/ctrl.sv
hw/hdu.sv
hw/pc_reg.sv
hw/ifu.sv
hw/pipe_reg.sv
hw/id_stage.sv
hw/core_frontend.sv
tests/tb_core_frontend.sv

/* Bender.yml */
package:
  name: core_frontend

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/core_pkg.sv
      - hw/ctrl.sv
      - hw/hdu.sv
      - hw/pc_reg.sv
      - hw/ifu.sv
      - hw/pipe_reg.sv
      - hw/id_stage.sv
      - hw/core_frontend.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/tb_core_frontend.sv

/* tests/tb_core_frontend.sv */
// inputs change 1 ns after the rising edge; memory returns only add, addi, lw and sw words
`timescale 1ns/1ps
`include "core_config.svh"

module tb_core_frontend;
    import core_pkg::*;

    localparam logic [31:0] SEED    = 32'haa23_97c0;
    localparam int          TIMEOUT = 200;                  // cycles allowed per wait
    localparam logic [31:0] TRAP_PC = 32'h0000_0100;

    logic                          clk;
    logic                          rst_n;
    logic                          imem_req;
    logic [`INST_ADDR_WIDTH-1:0]   imem_addr;
    logic                          imem_ack;
    logic [`INST_WIDTH-1:0]        imem_rdata;
    ex_fb_t                        ex_fb;
    logic                          clint_hold;
    id_ex_t                        id_ex;
    id_ex_t                        exp_pkt;
    logic [`INST_ADDR_WIDTH-1:0]   exp_pc;                  // pc of the next packet execute takes
    int                            max_delay;               // ack delay limit in cycles
    int                            ack_wait;
    int                            pkt_cnt;                 // packets taken by execute
    int                            err_cnt;
    int                            pass_cnt;
    int                            fail_cnt;

    core_frontend i_dut (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .imem_req_o   (imem_req),
        .imem_addr_o  (imem_addr),
        .imem_ack_i   (imem_ack),
        .imem_rdata_i (imem_rdata),
        .ex_fb_i      (ex_fb),
        .clint_hold_i (clint_hold),
        .id_ex_o      (id_ex)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] addr_hash(input logic [31:0] addr);
        logic [31:0] h;
        h = (addr >> 2) * 32'h9e37_79b9;
        return h ^ (h >> 15) ^ addr;                        // every address bit matters
    endfunction

    // [4:0] rd, [9:5] rs1, [14:10] rs2, [17:16] format
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] h;
        h = addr_hash(addr);
        case (h[17:16])
            2'd0:    return {7'b0, h[14:10], h[9:5], 3'b000, h[4:0], 7'b0110011};      // add
            2'd1:    return {h[29:18], h[9:5], 3'b000, h[4:0], 7'b0010011};            // addi
            2'd2:    return {h[29:18], h[9:5], 3'b010, h[4:0], 7'b0000011};            // lw
            default: return {h[31:25], h[14:10], h[9:5], 3'b010, h[4:0], 7'b0100011};  // sw
        endcase
    endfunction

    // expected decode of the word at pc from the hash fields it was built from
    function automatic id_ex_t ref_pkt(input logic [31:0] pc);
        logic [31:0] h;
        id_ex_t      p;
        h         = addr_hash(pc);
        p         = '0;
        p.valid   = 1'b1;
        p.pc      = pc;
        p.inst    = mem_word(pc);
        p.rs1     = h[9:5];
        p.use_rs1 = 1'b1;                                   // all four formats read rs1
        p.use_rs2 = (h[17:16] == 2'd0) || (h[17:16] == 2'd3);
        p.rs2     = p.use_rs2 ? h[14:10] : h[22:18];        // immediate bits for addi and lw
        p.rd      = (h[17:16] == 2'd3) ? 5'd0 : h[4:0];     // store writes nothing
        return p;
    endfunction

    // lowest register that none of the next eight words reads
    function automatic logic [4:0] unused_reg(input logic [31:0] pc);
        id_ex_t      p;
        logic [31:0] used;
        logic [4:0]  r;
        used = 32'h1;
        r    = 5'd1;
        for (int i = 0; i < 8; i++) begin
            p = ref_pkt(pc + 32'(4 * i));
            if (p.use_rs1) used[p.rs1] = 1'b1;
            if (p.use_rs2) used[p.rs2] = 1'b1;
        end
        for (int k = 31; k > 0; k--) begin
            if (!used[k]) r = 5'(k);
        end
        return r;
    endfunction

    // four-phase memory that acks after a random delay
    always @(posedge clk) begin
        #1;
        if (!rst_n) begin
            imem_ack = 1'b0;
        end else if (imem_req && !imem_ack) begin
            if (ack_wait == 0) begin
                imem_ack   = 1'b1;
                imem_rdata = mem_word(imem_addr);
            end else begin
                ack_wait--;
            end
        end else if (!imem_req && imem_ack) begin
            imem_ack = 1'b0;
            ack_wait = $urandom_range(max_delay, 0);
        end else if (imem_req && imem_ack) begin
            assert (1'b0) else begin
                $display("protocol error: request raised again before acknowledge dropped");
                err_cnt++;
            end
        end
    end

    // execute takes id_ex at the coming edge unless it holds
    always @(negedge clk) begin
        if (rst_n && id_ex.valid && !ex_fb.hold) begin
            exp_pkt = ref_pkt(exp_pc);
            assert (id_ex == exp_pkt) else begin
                $display("mismatch at %0t: id_ex %h, expected %h", $time, id_ex, exp_pkt);
                err_cnt++;
            end
            exp_pc = exp_pc + 32'd4;
            pkt_cnt++;
        end
        if (rst_n && ex_fb.jump_flag) begin
            exp_pc = ex_fb.jump_addr;                       // new path starts at the target
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_packets(input int n);
        int target;
        int cycles;
        target = pkt_cnt + n;
        cycles = 0;
        while ((pkt_cnt < target) && (cycles < TIMEOUT)) begin
            next_cycle();
            cycles++;
        end
        assert (pkt_cnt >= target) else begin
            $display("timeout: pipeline stalled, only %0d of %0d packets arrived in %0d cycles",
                     n - (target - pkt_cnt), n, TIMEOUT);
            err_cnt++;
        end
    endtask

    task automatic wait_for_valid();
        int cycles;
        cycles = 0;
        while (!id_ex.valid && (cycles < TIMEOUT)) begin
            next_cycle();
            cycles++;
        end
        assert (id_ex.valid) else begin
            $display("timeout: no valid packet reached execute in %0d cycles", TIMEOUT);
            err_cnt++;
        end
    endtask

    task automatic finish_test(input string name, input int errs);
        if (err_cnt == errs) begin
            $display("test %s: passed", name);
            pass_cnt++;
        end else begin
            $display("test %s: failed with %0d errors", name, err_cnt - errs);
            fail_cnt++;
        end
    endtask

    task automatic reset_and_fetch();
        int errs;
        errs      = err_cnt;
        max_delay = 0;
        repeat (10) @(posedge clk);
        #1;
        assert (!imem_req && !id_ex.valid) else begin
            $display("mismatch at %0t: req %b valid %b at the end of reset",
                     $time, imem_req, id_ex.valid);
            err_cnt++;
        end
        rst_n = 1'b1;
        wait_packets(8);
        finish_test("reset and sequential fetch", errs);
    endtask

    task automatic memory_backpressure();
        int errs;
        errs      = err_cnt;
        max_delay = 4;
        wait_packets(12);
        finish_test("memory back-pressure", errs);
    endtask

    task automatic jump_redirect();
        int errs;
        errs      = err_cnt;
        max_delay = 2;
        wait_packets(2);
        repeat ($urandom_range(5, 0)) next_cycle();
        ex_fb.jump_flag = 1'b1;
        ex_fb.jump_addr = $urandom & 32'h0000_fffc;         // aligned target
        next_cycle();
        ex_fb.jump_flag = 1'b0;
        wait_packets(6);
        finish_test("jump redirect", errs);
    endtask

    task automatic execute_hold();
        int     errs;
        id_ex_t snap;
        errs = err_cnt;
        wait_for_valid();
        ex_fb.hold = 1'b1;
        snap       = id_ex;
        repeat (6) begin
            next_cycle();
            assert (id_ex == snap) else begin
                $display("mismatch at %0t: id_ex pc %h changed under execute hold, was %h",
                         $time, id_ex.pc, snap.pc);
                err_cnt++;
            end
        end
        ex_fb.hold = 1'b0;
        wait_packets(4);
        finish_test("execute hold", errs);
    endtask

    task automatic load_use_stall();
        int     errs;
        int     base;
        id_ex_t tgt;
        errs      = err_cnt;
        max_delay = 0;
        for (int tries = 0; tries < 20; tries++) begin
            wait_for_valid();
            tgt = ref_pkt(exp_pc + 32'd4);                  // word that enters decode next
            if (tgt.rs1 != 5'd0) break;
            next_cycle();
        end
        ex_fb.load_valid = 1'b1;
        ex_fb.load_rd    = tgt.rs1;
        repeat (10) begin
            next_cycle();
            assert (!id_ex.valid) else begin
                $display("mismatch at %0t: valid packet pc %h during load-use stall",
                         $time, id_ex.pc);
                err_cnt++;
            end
        end
        ex_fb.load_valid = 1'b0;
        wait_packets(2);
        for (int k = 0; k < 2; k++) begin
            base             = pkt_cnt;
            ex_fb.load_valid = 1'b1;
            ex_fb.load_rd    = (k == 0) ? unused_reg(exp_pc) : 5'd0;
            repeat (24) next_cycle();
            assert (pkt_cnt - base >= 3) else begin
                $display("load destination x%0d stalled the pipeline though no word reads it",
                         ex_fb.load_rd);
                err_cnt++;
            end
        end
        ex_fb.load_valid = 1'b0;
        finish_test("load-use stall", errs);
    endtask

    task automatic interrupt_hold();
        int errs;
        errs      = err_cnt;
        max_delay = 4;
        repeat ($urandom_range(6, 2)) next_cycle();
        clint_hold = 1'b1;
        repeat (8) begin
            next_cycle();
            assert (!id_ex.valid) else begin
                $display("mismatch at %0t: valid packet pc %h under interrupt hold",
                         $time, id_ex.pc);
                err_cnt++;
            end
        end
        clint_hold      = 1'b0;
        ex_fb.jump_flag = 1'b1;                             // trap entry
        ex_fb.jump_addr = TRAP_PC;
        next_cycle();
        ex_fb.jump_flag = 1'b0;
        wait_packets(4);
        finish_test("interrupt hold", errs);
    endtask

    initial begin
        void'($urandom(SEED));
        clk        = 1'b0;
        rst_n      = 1'b0;
        imem_ack   = 1'b0;
        imem_rdata = '0;
        ex_fb      = '0;
        clint_hold = 1'b0;
        exp_pc     = `RESET_PC;
        max_delay  = 0;
        ack_wait   = 0;
        pkt_cnt    = 0;
        err_cnt    = 0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        reset_and_fetch();
        memory_backpressure();
        jump_redirect();
        execute_hold();
        load_use_stall();
        interrupt_hold();
        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if ((fail_cnt == 0) && (err_cnt == 0)) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* hw/core_frontend.sv */
// ID/EX output has no ready signal; execute must stall the front end through ex_fb_i.hold
`timescale 1ns/1ps
`include "core_config.svh"

module core_frontend (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    output logic                          imem_req_o,
    output logic [`INST_ADDR_WIDTH-1:0]   imem_addr_o,
    input  logic                          imem_ack_i,
    input  logic [`INST_WIDTH-1:0]        imem_rdata_i,
    input  core_pkg::ex_fb_t              ex_fb_i,      // execute feedback
    input  logic                          clint_hold_i, // interrupt freeze
    output core_pkg::id_ex_t              id_ex_o       // toward execute
);
    import core_pkg::*;

    hold_e                         hold;
    logic                          hold_hdu;
    logic                          jump_flag;
    logic [`INST_ADDR_WIDTH-1:0]   jump_addr;
    logic [`INST_ADDR_WIDTH-1:0]   pc;
    logic                          advance;
    if_id_t                        fetch;
    if_id_t                        if_id_q;
    id_ex_t                        id_pkt;
    logic                          if_id_hold;
    logic                          if_id_bubble;
    logic                          id_ex_hold;
    logic                          id_ex_bubble;

    // hold code to per register controls
    assign if_id_bubble = (hold == HOLD_FLUSH);
    assign if_id_hold   = (hold == HOLD_ID) || (hold == HOLD_IF);
    assign id_ex_bubble = (hold == HOLD_FLUSH) || (hold == HOLD_IF);
    assign id_ex_hold   = (hold == HOLD_ID);

    ctrl i_ctrl (
        .ex_fb_i      (ex_fb_i),
        .clint_hold_i (clint_hold_i),
        .hold_hdu_i   (hold_hdu),
        .hold_o       (hold),
        .jump_flag_o  (jump_flag),
        .jump_addr_o  (jump_addr)
    );

    pc_reg i_pc_reg (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .hold_i      (hold),
        .jump_flag_i (jump_flag),
        .jump_addr_i (jump_addr),
        .advance_i   (advance),
        .pc_o        (pc)
    );

    ifu i_ifu (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .pc_i         (pc),
        .hold_i       (hold),
        .imem_req_o   (imem_req_o),
        .imem_addr_o  (imem_addr_o),
        .imem_ack_i   (imem_ack_i),
        .imem_rdata_i (imem_rdata_i),
        .fetch_o      (fetch),
        .advance_o    (advance)
    );

    pipe_reg #(.payload_t(if_id_t)) i_if_id (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .hold_i   (if_id_hold),
        .bubble_i (if_id_bubble),
        .d_i      (fetch),
        .q_o      (if_id_q)
    );

    id_stage i_id_stage (
        .if_id_i  (if_id_q),
        .id_pkt_o (id_pkt)
    );

    hdu i_hdu (
        .id_pkt_i (id_pkt),
        .ex_fb_i  (ex_fb_i),
        .hold_o   (hold_hdu)
    );

    pipe_reg #(.payload_t(id_ex_t)) i_id_ex (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .hold_i   (id_ex_hold),
        .bubble_i (id_ex_bubble),
        .d_i      (id_pkt),
        .q_o      (id_ex_o)
    );

endmodule

/* hw/id_stage.sv */
// rv32i base opcodes only; unknown opcodes read no registers and keep their raw rd field
`timescale 1ns/1ps
`include "core_config.svh"

module id_stage (
    input  core_pkg::if_id_t   if_id_i,
    output core_pkg::id_ex_t   id_pkt_o
);

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    logic [`INST_WIDTH-1:0] inst;
    logic [6:0]             opcode;
    logic                   use_rs1;
    logic                   use_rs2;
    logic                   no_rd;

    // empty slots decode as nop
    assign inst   = if_id_i.valid ? if_id_i.inst : `NOP_INST;
    assign opcode = inst[6:0];

    always_comb begin
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        no_rd   = 1'b0;
        case (opcode)
            OPC_LUI, OPC_AUIPC, OPC_JAL: begin
                use_rs1 = 1'b0;                     // immediate or pc only
            end
            OPC_JALR, OPC_LOAD, OPC_OP_IMM: begin
                use_rs1 = 1'b1;
            end
            OPC_OP: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            OPC_BRANCH, OPC_STORE: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                no_rd   = 1'b1;                     // bits 11:7 are immediate here
            end
            default: begin
                use_rs1 = 1'b0;
            end
        endcase
    end

    assign id_pkt_o.valid   = if_id_i.valid;
    assign id_pkt_o.pc      = if_id_i.pc;
    assign id_pkt_o.inst    = inst;
    assign id_pkt_o.rs1     = inst[19:15];
    assign id_pkt_o.rs2     = inst[24:20];
    assign id_pkt_o.rd      = no_rd ? 5'd0 : inst[11:7];
    assign id_pkt_o.use_rs1 = use_rs1;
    assign id_pkt_o.use_rs2 = use_rs2;

endmodule

/* hw/pipe_reg.sv */
// bubble clears the whole payload to zero so the payload type must mark empty slots by a zero valid bit
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic                // stage packet type
) (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       hold_i,                      // keep current content
    input  logic       bubble_i,                    // insert empty slot
    input  payload_t   d_i,
    output payload_t   q_o
);

    payload_t q_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            q_q <= '0;
        end else if (bubble_i) begin
            q_q <= '0;                              // bubble wins over hold
        end else if (!hold_i) begin
            q_q <= d_i;
        end
    end

    assign q_o = q_q;

endmodule

/* hw/ifu.sv */
// one word in flight and one buffered; the next request waits for the buffer to drain
`timescale 1ns/1ps
`include "core_config.svh"

module ifu (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic [`INST_ADDR_WIDTH-1:0]   pc_i,
    input  core_pkg::hold_e               hold_i,
    output logic                          imem_req_o,
    output logic [`INST_ADDR_WIDTH-1:0]   imem_addr_o,
    input  logic                          imem_ack_i,
    input  logic [`INST_WIDTH-1:0]        imem_rdata_i,
    output core_pkg::if_id_t              fetch_o,      // to IF/ID
    output logic                          advance_o     // to pc_reg
);
    import core_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,                                     // req low and ack low
        S_REQ,                                      // req high until ack
        S_REL,                                      // req just dropped
        S_WAIT                                      // ack still high
    } state_e;

    state_e                        state_q;
    state_e                        state_d;
    logic [`INST_ADDR_WIDTH-1:0]   addr_q;          // held from req rise to ack fall
    logic                          buf_valid_q;
    logic [`INST_WIDTH-1:0]        buf_inst_q;
    logic                          drop_q;          // in-flight word is stale
    logic                          flush;
    logic                          start;
    logic                          capture;

    assign flush   = (hold_i == HOLD_FLUSH);
    assign start   = (state_q == S_IDLE) && !buf_valid_q && (hold_i == HOLD_NONE);
    assign capture = (state_q == S_REQ) && imem_ack_i && !drop_q && !flush;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE:  if (start) state_d = S_REQ;
            S_REQ:   if (imem_ack_i) state_d = S_REL;
            S_REL:   state_d = imem_ack_i ? S_WAIT : S_IDLE;
            S_WAIT:  if (!imem_ack_i) state_d = S_IDLE;
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q     <= S_IDLE;
            addr_q      <= `RESET_PC;
            drop_q      <= 1'b0;
            buf_valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (start) begin
                addr_q <= pc_i;                     // latch fetch address with req
            end
            if (state_q == S_REQ) begin
                if (imem_ack_i) begin
                    drop_q <= 1'b0;                 // handshake done
                end else if (flush) begin
                    drop_q <= 1'b1;                 // finish handshake but discard
                end
            end
            if (flush) begin
                buf_valid_q <= 1'b0;
            end else if (capture) begin
                buf_valid_q <= 1'b1;
            end else if (advance_o) begin
                buf_valid_q <= 1'b0;                // taken by IF/ID
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture) begin
            buf_inst_q <= imem_rdata_i;
        end
    end

    assign imem_req_o  = (state_q == S_REQ);
    assign imem_addr_o = addr_q;

    assign fetch_o.valid = buf_valid_q;
    assign fetch_o.pc    = addr_q;                  // buffer word came from addr_q
    assign fetch_o.inst  = buf_inst_q;

    // exactly one advance per accepted word
    assign advance_o = buf_valid_q && (hold_i == HOLD_NONE);

endmodule

/* hw/pc_reg.sv */
// steps by 4 only; a flush without a jump freezes the PC until a jump arrives
`timescale 1ns/1ps
`include "core_config.svh"

module pc_reg (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  core_pkg::hold_e               hold_i,
    input  logic                          jump_flag_i,
    input  logic [`INST_ADDR_WIDTH-1:0]   jump_addr_i,
    input  logic                          advance_i,    // fetched word accepted by IF/ID
    output logic [`INST_ADDR_WIDTH-1:0]   pc_o
);
    import core_pkg::*;

    logic [`INST_ADDR_WIDTH-1:0] pc_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q <= `RESET_PC;
        end else if (hold_i == HOLD_FLUSH) begin
            if (jump_flag_i) begin
                pc_q <= jump_addr_i;                // redirect
            end                                     // otherwise frozen for interrupt
        end else if ((hold_i == HOLD_NONE) && advance_i) begin
            pc_q <= pc_q + `INST_ADDR_WIDTH'd4;     // next sequential word
        end
    end

    assign pc_o = pc_q;

endmodule

/* hw/hdu.sv */
// load-use only; no forwarding is modelled so any match with a pending load stalls decode
`timescale 1ns/1ps

module hdu (
    input  core_pkg::id_ex_t   id_pkt_i,   // packet currently in decode
    input  core_pkg::ex_fb_t   ex_fb_i,    // pending load in execute
    output logic               hold_o      // stall request to ctrl
);

    logic rs1_hit;
    logic rs2_hit;

    // x0 never depends on anything
    assign rs1_hit = id_pkt_i.use_rs1
                  && (id_pkt_i.rs1 != 5'd0)
                  && (id_pkt_i.rs1 == ex_fb_i.load_rd);

    assign rs2_hit = id_pkt_i.use_rs2
                  && (id_pkt_i.rs2 != 5'd0)
                  && (id_pkt_i.rs2 == ex_fb_i.load_rd);

    // bubbles in decode never stall
    assign hold_o = ex_fb_i.load_valid && id_pkt_i.valid && (rs1_hit || rs2_hit);

endmodule

/* hw/ctrl.sv */
// purely combinational; a jump and the interrupt hold both map to HOLD_FLUSH and cannot be told apart
`timescale 1ns/1ps
`include "core_config.svh"

module ctrl (
    input  core_pkg::ex_fb_t              ex_fb_i,      // jump and hold from execute
    input  logic                          clint_hold_i, // interrupt controller hold
    input  logic                          hold_hdu_i,   // load use stall
    output core_pkg::hold_e               hold_o,
    output logic                          jump_flag_o,  // to pc_reg
    output logic [`INST_ADDR_WIDTH-1:0]   jump_addr_o
);
    import core_pkg::*;

    // jump goes straight through so redirect and flush share a cycle
    assign jump_flag_o = ex_fb_i.jump_flag;
    assign jump_addr_o = ex_fb_i.jump_addr;

    always_comb begin
        if (ex_fb_i.jump_flag || clint_hold_i) begin
            hold_o = HOLD_FLUSH;                    // highest priority
        end else if (ex_fb_i.hold) begin
            hold_o = HOLD_ID;                       // execute busy
        end else if (hold_hdu_i) begin
            hold_o = HOLD_IF;                       // load use bubble
        end else begin
            hold_o = HOLD_NONE;
        end
    end

endmodule

/* hw/core_pkg.sv */
// hold codes are ordered by priority and ctrl relies on that order; the payload structs carry no parity
`include "core_config.svh"

package core_pkg;

    // pipeline hold code sent from ctrl to every stage
    typedef enum logic [1:0] {
        HOLD_NONE  = 2'b00,                         // pipeline runs freely
        HOLD_IF    = 2'b01,                         // stall fetch and IF/ID and bubble ID/EX
        HOLD_ID    = 2'b10,                         // stall everything up to ID/EX
        HOLD_FLUSH = 2'b11                          // redirect or freeze PC and drop both stages
    } hold_e;

    // fetch to decode packet
    typedef struct packed {
        logic                          valid;       // slot carries an instruction
        logic [`INST_ADDR_WIDTH-1:0]   pc;          // address the word was fetched from
        logic [`INST_WIDTH-1:0]        inst;        // raw instruction word
    } if_id_t;

    // decode to execute packet
    typedef struct packed {
        logic                          valid;
        logic [`INST_ADDR_WIDTH-1:0]   pc;
        logic [`INST_WIDTH-1:0]        inst;
        logic [4:0]                    rs1;         // source index 1
        logic [4:0]                    rs2;         // source index 2
        logic [4:0]                    rd;          // zero when nothing is written back
        logic                          use_rs1;     // rs1 is actually read
        logic                          use_rs2;     // rs2 is actually read
    } id_ex_t;

    // feedback from the execute stage
    typedef struct packed {
        logic                          jump_flag;   // taken branch or jump this cycle
        logic [`INST_ADDR_WIDTH-1:0]   jump_addr;   // redirect target
        logic                          hold;        // multi cycle op still busy
        logic                          load_valid;  // load in execute with data not ready
        logic [4:0]                    load_rd;     // destination of that load
    } ex_fb_t;

endpackage

/* hw/core_config.svh */
// rv32 widths only; RESET_PC must be word aligned because fetch never handles misaligned addresses
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// instruction address width in bits
`define INST_ADDR_WIDTH 32

// instruction word width in bits
`define INST_WIDTH 32

// first fetch address out of reset
`define RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define NOP_INST 32'h0000_0013

`endif
